//--- all.f
+incdir+source
source/ps2_pkg.sv
source/ps2_frame_receiver.sv
source/xt_code_translator.sv
source/break_prefix_tracker.sv
source/scan_code_output.sv
source/ps2_keyboard.sv
bench/scan_code_checker.sv
bench/ps2_keyboard_tb.sv

//--- bench/ps2_keyboard_tb.sv
// PS/2 bits last 20 system clocks; frames are sent one after another and never overlap
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

module ps2_keyboard_tb;

  localparam int MAKE_FRAMES   = 40;
  localparam int BREAK_ROUNDS  = 4;
  localparam int EXT_FRAMES    = 10;
  localparam int TOTAL_FRAMES  = MAKE_FRAMES + 3 * BREAK_ROUNDS + EXT_FRAMES + 2 + 1;
  localparam int FRAME_CYCLES  = 230;
  localparam int RESET_CYCLES  = 16;
  localparam int IDLE_CYCLES   = 20;
  localparam int WATCHDOG_HOLD = 700;
  // Partial frame of five bits plus the long idle clock
  localparam int CYCLE_LIMIT   = 2 * TOTAL_FRAMES * FRAME_CYCLES + RESET_CYCLES
                                 + IDLE_CYCLES + 5 * 20 + WATCHDOG_HOLD;

  logic                wb_clk = 1'b0;
  logic                wb_rst;
  logic                ps2_clk;
  logic                ps2_data;
  logic                frame_sent;
  logic                hold_check;
  ps2_pkg::scan_code_t sent_code;
  ps2_pkg::scan_code_t wb_dat;
  logic                wb_tgc;
  logic [31:0]         lfsr = 32'hce37;
  int                  cycle_count = 0;
  int                  error_count;
  int                  check_count;
  int                  errors_before = 0;
  int                  test_count = 0;

  always #50 wb_clk = ~wb_clk;

  ps2_keyboard dut_i (
    .wb_clk_i   (wb_clk),
    .wb_rst_i   (wb_rst),
    .ps2_clk_i  (ps2_clk),
    .ps2_data_i (ps2_data),
    .wb_dat_o   (wb_dat),
    .wb_tgc_o   (wb_tgc)
  );

  scan_code_checker code_check_i (
    .wb_clk_i      (wb_clk),
    .wb_rst_i      (wb_rst),
    .wb_tgc_i      (wb_tgc),
    .wb_dat_i      (wb_dat),
    .frame_sent_i  (frame_sent),
    .sent_code_i   (sent_code),
    .hold_check_i  (hold_check),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  // Galois LFSR with taps for x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'ha300_0000;
    return state >> 1;
  endfunction

  task automatic take_bits(input int count, output ps2_pkg::scan_code_t value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  // Non-zero code below 80
  task automatic random_make(output ps2_pkg::scan_code_t code);
    code = '0;
    while (code == '0)
      take_bits(7, code);
  endtask

  task automatic random_extended(output ps2_pkg::scan_code_t code);
    code = `PS2_RELEASE_CODE;
    while (code == `PS2_RELEASE_CODE)
    begin
      take_bits(7, code);
      code[7] = 1'b1;
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic next_cycle;
    @(posedge wb_clk);
    #10;
  endtask

  // Start bit, data LSB first, odd parity and stop bit
  task automatic send_bits(input ps2_pkg::scan_code_t code, input int bit_total);
    logic [`PS2_FRAME_BITS-1:0] frame;
    frame = {1'b1, ~^code, code, 1'b0};
    sent_code = code;
    for (int i = 0; i < bit_total; i++)
    begin
      next_cycle();
      ps2_data = frame[i];
      repeat (9) next_cycle();
      ps2_clk    = 1'b0;
      frame_sent = (i == `PS2_FRAME_BITS - 1);
      next_cycle();
      frame_sent = 1'b0;
      repeat (9) next_cycle();
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
  endtask

  task automatic send_frame(input ps2_pkg::scan_code_t code);
    send_bits(code, `PS2_FRAME_BITS);
    repeat (10) next_cycle();
  endtask

  task automatic report_test(input string name, input int frames);
    test_count++;
    $display("Test %0d %s: %0d frames, %0d errors", test_count, name, frames,
             error_count - errors_before);
    errors_before = error_count;
  endtask

  // Run limit from the frame count, reset and watchdog test
  always @(posedge wb_clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles before the tests finished", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  initial
  begin
    ps2_pkg::scan_code_t code;
    wb_rst     = 1'b1;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    frame_sent = 1'b0;
    hold_check = 1'b0;
    sent_code  = '0;
    repeat (RESET_CYCLES) next_cycle();
    wb_rst = 1'b0;

    // Output must stay at zero on idle lines
    repeat (IDLE_CYCLES) next_cycle();
    hold_check = 1'b1;
    next_cycle();
    hold_check = 1'b0;
    report_test("reset values", 0);

    for (int i = 0; i < MAKE_FRAMES; i++)
    begin
      random_make(code);
      send_frame(code);
    end
    report_test("make codes", MAKE_FRAMES);

    // Prefix followed by a flagged code and a plain code
    for (int i = 0; i < BREAK_ROUNDS; i++)
    begin
      send_frame(`PS2_RELEASE_CODE);
      random_make(code);
      send_frame(code);
      random_make(code);
      send_frame(code);
    end
    report_test("break codes", 3 * BREAK_ROUNDS);

    for (int i = 0; i < EXT_FRAMES; i++)
    begin
      random_extended(code);
      send_frame(code);
    end
    report_test("extended codes", EXT_FRAMES);

    // A raw byte first keeps the held value apart from the 7F a zero would load
    random_extended(code);
    send_frame(code);
    send_frame(8'h00);
    report_test("zero code", 2);

    // Five bits followed by a stuck high clock
    random_make(code);
    send_bits(code, 5);
    repeat (WATCHDOG_HOLD) next_cycle();
    random_make(code);
    send_frame(code);
    report_test("watchdog", 1);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/scan_code_checker.sv
// Expects one frame at a time and the wb_tgc_o pulse within 8 cycles of the eleventh falling edge
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

module scan_code_checker (
  input  wire                      wb_clk_i,
  input  wire                      wb_rst_i,
  input  wire                      wb_tgc_i,
  input  wire ps2_pkg::scan_code_t wb_dat_i,
  input  wire                      frame_sent_i,
  input  wire ps2_pkg::scan_code_t sent_code_i,
  input  wire                      hold_check_i,
  output int                       error_count_o,
  output int                       check_count_o
);

  // Cycles after the last falling edge in which the pulse must show
  localparam int PULSE_WINDOW = 8;

  logic [6:0]          xt_table [0:127];
  ps2_pkg::scan_code_t exp_dat;
  logic                break_model;
  logic                expect_pulse;
  logic                pulse_seen;
  int                  window;

  // AT set-2 to XT set-1 reference, eight entries per line
  initial
  begin
    xt_table = '{
      7'h7f, 7'h43, 7'h41, 7'h3f, 7'h3d, 7'h3b, 7'h3c, 7'h58,
      7'h64, 7'h44, 7'h42, 7'h40, 7'h3e, 7'h0f, 7'h29, 7'h59,
      7'h65, 7'h38, 7'h2a, 7'h70, 7'h1d, 7'h10, 7'h02, 7'h5a,
      7'h66, 7'h71, 7'h2c, 7'h1f, 7'h1e, 7'h11, 7'h03, 7'h5b,
      7'h67, 7'h2e, 7'h2d, 7'h20, 7'h12, 7'h05, 7'h04, 7'h5c,
      7'h68, 7'h39, 7'h2f, 7'h21, 7'h14, 7'h13, 7'h06, 7'h5d,
      7'h69, 7'h31, 7'h30, 7'h23, 7'h22, 7'h15, 7'h07, 7'h5e,
      7'h6a, 7'h72, 7'h32, 7'h24, 7'h16, 7'h08, 7'h09, 7'h5f,
      7'h6b, 7'h33, 7'h25, 7'h17, 7'h18, 7'h0b, 7'h0a, 7'h60,
      7'h6c, 7'h34, 7'h35, 7'h26, 7'h27, 7'h19, 7'h0c, 7'h61,
      7'h6d, 7'h73, 7'h28, 7'h74, 7'h1a, 7'h0d, 7'h62, 7'h6e,
      7'h3a, 7'h36, 7'h1c, 7'h1b, 7'h75, 7'h2b, 7'h63, 7'h76,
      7'h55, 7'h56, 7'h77, 7'h78, 7'h79, 7'h7a, 7'h0e, 7'h7b,
      7'h7c, 7'h4f, 7'h7d, 7'h4b, 7'h47, 7'h7e, 7'h7f, 7'h6f,
      7'h52, 7'h53, 7'h50, 7'h4c, 7'h4d, 7'h48, 7'h01, 7'h45,
      7'h57, 7'h4e, 7'h51, 7'h4a, 7'h37, 7'h49, 7'h46, 7'h54
    };
  end

  task automatic compare_dat(input ps2_pkg::scan_code_t expected);
    check_count_o++;
    if (wb_dat_i !== expected)
    begin
      error_count_o++;
      $display("[ERROR] %0t ns: wb_dat_o expected %02h, actual %02h",
               $time, expected, wb_dat_i);
    end
  endtask

  // Model of one completed frame
  task automatic predict(input ps2_pkg::scan_code_t code);
    window       = PULSE_WINDOW;
    pulse_seen   = 1'b0;
    expect_pulse = (code != `PS2_RELEASE_CODE);
    if (!expect_pulse)
      break_model = 1'b1;
    else
    begin
      // High codes pass raw, zero keeps the old byte
      if (code[7])
        exp_dat = code;
      else if (code != 8'h00)
        exp_dat = {break_model, xt_table[code[6:0]]};
      break_model = 1'b0;
    end
  endtask

  always @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      exp_dat      = '0;
      break_model  = 1'b0;
      expect_pulse = 1'b0;
      pulse_seen   = 1'b0;
      window       = 0;
    end
    else
    begin
      // Pulse only counts inside an open window, and only once
      if (wb_tgc_i)
      begin
        if ((window > 0) && expect_pulse && !pulse_seen)
        begin
          pulse_seen = 1'b1;
          compare_dat(exp_dat);
        end
        else
        begin
          error_count_o++;
          $display("%0t ns: wb_tgc_o pulsed when no pulse was expected", $time);
        end
      end
      if (window > 0)
      begin
        window--;
        if (window == 0)
        begin
          check_count_o++;
          if (expect_pulse && !pulse_seen)
          begin
            error_count_o++;
            $display("%0t ns: no wb_tgc_o pulse within %0d cycles of the frame end",
                     $time, PULSE_WINDOW);
          end
          else if (!expect_pulse)
            compare_dat(exp_dat);
        end
      end
      if (hold_check_i)
        compare_dat(exp_dat);
      if (frame_sent_i)
        predict(sent_code_i);
    end
  end

endmodule

`default_nettype wire

//--- source/ps2_keyboard.sv
// Receive-only PS/2 keyboard to XT host; PS/2 lines are inputs and the device is never written
`timescale 1ns/10ps
`default_nettype none

module ps2_keyboard (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 ps2_clk_i,
  input  wire                 ps2_data_i,
  output ps2_pkg::scan_code_t wb_dat_o,
  output logic                wb_tgc_o
);

  logic                frame_done;
  ps2_pkg::scan_code_t code;
  ps2_pkg::xt_code_t   xt_code;
  logic                is_release;
  logic                break_pending;

  // Line sampling and frame assembly
  ps2_frame_receiver u_receiver (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .ps2_clk_i    (ps2_clk_i),
    .ps2_data_i   (ps2_data_i),
    .frame_done_o (frame_done),
    .code_o       (code)
  );

  // Bit 7 is handled in the output stage
  xt_code_translator u_translator (
    .at_code_i (code[6:0]),
    .xt_code_o (xt_code)
  );

  break_prefix_tracker u_tracker (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .frame_done_i    (frame_done),
    .code_i          (code),
    .is_release_o    (is_release),
    .break_pending_o (break_pending)
  );

  // Host side registers
  scan_code_output u_output (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .frame_done_i    (frame_done),
    .code_i          (code),
    .xt_code_i       (xt_code),
    .is_release_i    (is_release),
    .break_pending_i (break_pending),
    .wb_tgc_o        (wb_tgc_o),
    .wb_dat_o        (wb_dat_o)
  );

endmodule

`default_nettype wire

//--- source/scan_code_output.sv
// No back-pressure; the host must take wb_dat_o on each wb_tgc_o pulse before the next
`timescale 1ns/10ps
`default_nettype none

module scan_code_output (
  input  wire                      wb_clk_i,
  input  wire                      wb_rst_i,
  input  wire                      frame_done_i,
  input  wire ps2_pkg::scan_code_t code_i,
  input  wire ps2_pkg::xt_code_t   xt_code_i,
  input  wire                      is_release_i,
  input  wire                      break_pending_i,
  output logic                     wb_tgc_o,
  output ps2_pkg::scan_code_t      wb_dat_o
);

  logic out_strobe;
  logic load_data;

  // Prefix frames are swallowed
  assign out_strobe = frame_done_i && !is_release_i;

  // Zero code still interrupts but keeps the old byte
  assign load_data = out_strobe && (code_i != '0);

  // Interrupt pulse to the host
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      wb_tgc_o <= 1'b0;
    else
      wb_tgc_o <= out_strobe;
  end

  // High codes go out raw, others as break flag plus XT code
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      wb_dat_o <= '0;
    else if (load_data)
    begin
      if (code_i[7])
        wb_dat_o <= code_i;
      else
        wb_dat_o <= {break_pending_i, xt_code_i};
    end
  end

endmodule

`default_nettype wire

//--- source/break_prefix_tracker.sv
// Only the F0 break prefix is tracked; E0 extended prefixes pass through untouched
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

module break_prefix_tracker (
  input  wire                      wb_clk_i,
  input  wire                      wb_rst_i,
  input  wire                      frame_done_i,
  input  wire ps2_pkg::scan_code_t code_i,
  output logic                     is_release_o,
  output logic                     break_pending_o
);

  // High only in the strobe cycle of a prefix frame
  assign is_release_o = frame_done_i && (code_i == `PS2_RELEASE_CODE);

  // Every completed frame rewrites the flag
  // A prefix sets it, the next code clears it
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      break_pending_o <= 1'b0;
    else if (frame_done_i)
      break_pending_o <= is_release_o;
  end

  // Flag rises only on the edge that ends a frame strobe
  break_rise_after_frame : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(break_pending_o) |-> $past(frame_done_i));

endmodule

`default_nettype wire

//--- source/xt_code_translator.sv
// AT set-2 to XT set-1 lookup for the low 7 code bits only; codes with bit 7 set bypass it
`timescale 1ns/10ps
`default_nettype none

module xt_code_translator (
  // Low seven bits of the AT scan code
  input  wire ps2_pkg::xt_code_t at_code_i,
  output ps2_pkg::xt_code_t      xt_code_o
);

  // Unused AT codes map to 7F or to spare XT codes
  always_comb
  begin
    case (at_code_i)
      7'h00: xt_code_o = 7'h7f;
      7'h01: xt_code_o = 7'h43;
      7'h02: xt_code_o = 7'h41;
      7'h03: xt_code_o = 7'h3f;
      7'h04: xt_code_o = 7'h3d;
      7'h05: xt_code_o = 7'h3b;
      7'h06: xt_code_o = 7'h3c;
      7'h07: xt_code_o = 7'h58;
      7'h08: xt_code_o = 7'h64;
      7'h09: xt_code_o = 7'h44;
      7'h0a: xt_code_o = 7'h42;
      7'h0b: xt_code_o = 7'h40;
      7'h0c: xt_code_o = 7'h3e;
      7'h0d: xt_code_o = 7'h0f;
      7'h0e: xt_code_o = 7'h29;
      7'h0f: xt_code_o = 7'h59;
      7'h10: xt_code_o = 7'h65;
      7'h11: xt_code_o = 7'h38;
      7'h12: xt_code_o = 7'h2a;
      7'h13: xt_code_o = 7'h70;
      7'h14: xt_code_o = 7'h1d;
      7'h15: xt_code_o = 7'h10;
      7'h16: xt_code_o = 7'h02;
      7'h17: xt_code_o = 7'h5a;
      7'h18: xt_code_o = 7'h66;
      7'h19: xt_code_o = 7'h71;
      7'h1a: xt_code_o = 7'h2c;
      7'h1b: xt_code_o = 7'h1f;
      7'h1c: xt_code_o = 7'h1e;
      7'h1d: xt_code_o = 7'h11;
      7'h1e: xt_code_o = 7'h03;
      7'h1f: xt_code_o = 7'h5b;
      7'h20: xt_code_o = 7'h67;
      7'h21: xt_code_o = 7'h2e;
      7'h22: xt_code_o = 7'h2d;
      7'h23: xt_code_o = 7'h20;
      7'h24: xt_code_o = 7'h12;
      7'h25: xt_code_o = 7'h05;
      7'h26: xt_code_o = 7'h04;
      7'h27: xt_code_o = 7'h5c;
      7'h28: xt_code_o = 7'h68;
      7'h29: xt_code_o = 7'h39;
      7'h2a: xt_code_o = 7'h2f;
      7'h2b: xt_code_o = 7'h21;
      7'h2c: xt_code_o = 7'h14;
      7'h2d: xt_code_o = 7'h13;
      7'h2e: xt_code_o = 7'h06;
      7'h2f: xt_code_o = 7'h5d;
      7'h30: xt_code_o = 7'h69;
      7'h31: xt_code_o = 7'h31;
      7'h32: xt_code_o = 7'h30;
      7'h33: xt_code_o = 7'h23;
      7'h34: xt_code_o = 7'h22;
      7'h35: xt_code_o = 7'h15;
      7'h36: xt_code_o = 7'h07;
      7'h37: xt_code_o = 7'h5e;
      7'h38: xt_code_o = 7'h6a;
      7'h39: xt_code_o = 7'h72;
      7'h3a: xt_code_o = 7'h32;
      7'h3b: xt_code_o = 7'h24;
      7'h3c: xt_code_o = 7'h16;
      7'h3d: xt_code_o = 7'h08;
      7'h3e: xt_code_o = 7'h09;
      7'h3f: xt_code_o = 7'h5f;
      7'h40: xt_code_o = 7'h6b;
      7'h41: xt_code_o = 7'h33;
      7'h42: xt_code_o = 7'h25;
      7'h43: xt_code_o = 7'h17;
      7'h44: xt_code_o = 7'h18;
      7'h45: xt_code_o = 7'h0b;
      7'h46: xt_code_o = 7'h0a;
      7'h47: xt_code_o = 7'h60;
      7'h48: xt_code_o = 7'h6c;
      7'h49: xt_code_o = 7'h34;
      7'h4a: xt_code_o = 7'h35;
      7'h4b: xt_code_o = 7'h26;
      7'h4c: xt_code_o = 7'h27;
      7'h4d: xt_code_o = 7'h19;
      7'h4e: xt_code_o = 7'h0c;
      7'h4f: xt_code_o = 7'h61;
      7'h50: xt_code_o = 7'h6d;
      7'h51: xt_code_o = 7'h73;
      7'h52: xt_code_o = 7'h28;
      7'h53: xt_code_o = 7'h74;
      7'h54: xt_code_o = 7'h1a;
      7'h55: xt_code_o = 7'h0d;
      7'h56: xt_code_o = 7'h62;
      7'h57: xt_code_o = 7'h6e;
      7'h58: xt_code_o = 7'h3a;
      7'h59: xt_code_o = 7'h36;
      7'h5a: xt_code_o = 7'h1c;
      7'h5b: xt_code_o = 7'h1b;
      7'h5c: xt_code_o = 7'h75;
      7'h5d: xt_code_o = 7'h2b;
      7'h5e: xt_code_o = 7'h63;
      7'h5f: xt_code_o = 7'h76;
      7'h60: xt_code_o = 7'h55;
      7'h61: xt_code_o = 7'h56;
      7'h62: xt_code_o = 7'h77;
      7'h63: xt_code_o = 7'h78;
      7'h64: xt_code_o = 7'h79;
      7'h65: xt_code_o = 7'h7a;
      7'h66: xt_code_o = 7'h0e;
      7'h67: xt_code_o = 7'h7b;
      7'h68: xt_code_o = 7'h7c;
      7'h69: xt_code_o = 7'h4f;
      7'h6a: xt_code_o = 7'h7d;
      7'h6b: xt_code_o = 7'h4b;
      7'h6c: xt_code_o = 7'h47;
      7'h6d: xt_code_o = 7'h7e;
      7'h6e: xt_code_o = 7'h7f;
      7'h6f: xt_code_o = 7'h6f;
      7'h70: xt_code_o = 7'h52;
      7'h71: xt_code_o = 7'h53;
      7'h72: xt_code_o = 7'h50;
      7'h73: xt_code_o = 7'h4c;
      7'h74: xt_code_o = 7'h4d;
      7'h75: xt_code_o = 7'h48;
      7'h76: xt_code_o = 7'h01;
      7'h77: xt_code_o = 7'h45;
      7'h78: xt_code_o = 7'h57;
      7'h79: xt_code_o = 7'h4e;
      7'h7a: xt_code_o = 7'h51;
      7'h7b: xt_code_o = 7'h4a;
      7'h7c: xt_code_o = 7'h37;
      7'h7d: xt_code_o = 7'h49;
      7'h7e: xt_code_o = 7'h46;
      7'h7f: xt_code_o = 7'h54;
      default: xt_code_o = 7'h7f;
    endcase
  end

endmodule

`default_nettype wire

//--- source/ps2_frame_receiver.sv
// Receive only; start, parity and stop bits are not checked and both lines must idle high
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

module ps2_frame_receiver (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 ps2_clk_i,
  input  wire                 ps2_data_i,
  output logic                frame_done_o,
  output ps2_pkg::scan_code_t code_o
);

  // Watchdog counter width for the idle-high limit
  localparam int WD_BITS = $clog2(`PS2_WATCHDOG_CYCLES);

  // Four receive states, markers last one cycle each
  typedef enum logic [1:0] {
    ST_CLK_H,
    ST_FALL_MARK,
    ST_CLK_L,
    ST_RISE_MARK
  } rx_state_t;

  rx_state_t                  state;
  rx_state_t                  state_next;
  logic                       ps2_clk_s;
  logic                       ps2_data_s;
  logic [`PS2_FRAME_BITS-1:0] shift_q;
  ps2_pkg::bit_count_t        bit_count;
  logic [WD_BITS-1:0]         wd_count;
  logic                       wd_enable;
  logic                       wd_done;

  // Single-stage input sampling, idle level is high
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      ps2_clk_s  <= 1'b1;
      ps2_data_s <= 1'b1;
    end
    else
    begin
      ps2_clk_s  <= ps2_clk_i;
      ps2_data_s <= ps2_data_i;
    end
  end

  // Next state and watchdog enable
  always_comb
  begin
    state_next = state;
    wd_enable  = 1'b0;
    case (state)
      ST_CLK_H:
      begin
        wd_enable = 1'b1;
        if (!ps2_clk_s)
          state_next = ST_FALL_MARK;
      end
      // Data bit is taken here
      ST_FALL_MARK:
        state_next = ST_CLK_L;
      ST_CLK_L:
      begin
        wd_enable = 1'b1;
        if (ps2_clk_s)
          state_next = ST_RISE_MARK;
      end
      ST_RISE_MARK:
        state_next = ST_CLK_H;
      default:
        state_next = ST_CLK_L;
    endcase
  end

  // Start in clock-low so a high line is seen before the first edge
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      state <= ST_CLK_L;
    else
      state <= state_next;
  end

  // Watchdog saturates at its limit and restarts at every marker
  assign wd_done = (wd_count == WD_BITS'(`PS2_WATCHDOG_CYCLES - 1));

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || !wd_enable)
      wd_count <= '0;
    else if (!wd_done)
      wd_count <= wd_count + 1'b1;
  end

  // Bit counter, cleared by a whole frame or a stalled one
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || frame_done_o)
      bit_count <= '0;
    else if (wd_done && (state == ST_CLK_H) && ps2_clk_s)
      bit_count <= '0;
    else if (state == ST_FALL_MARK)
      bit_count <= bit_count + 1'b1;
  end

  // LSB first, so the start bit ends in bit 0
  always_ff @(posedge wb_clk_i)
  begin
    if (state == ST_FALL_MARK)
      shift_q <= {ps2_data_s, shift_q[`PS2_FRAME_BITS-1:1]};
  end

  assign frame_done_o = (bit_count == ps2_pkg::bit_count_t'(`PS2_FRAME_BITS));

  // Data byte sits between start bit and parity bit
  assign code_o = shift_q[8:1];

  // Counter returns to zero right after the strobe
  frame_done_single : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    frame_done_o |=> !frame_done_o);

  bit_count_range : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    bit_count <= ps2_pkg::bit_count_t'(`PS2_FRAME_BITS));

endmodule

`default_nettype wire

//--- source/ps2_pkg.sv
// Shared types for the PS/2 receiver; widths are fixed for 8-bit scan codes
`default_nettype none

package ps2_pkg;

  // One data byte of a received PS/2 frame
  typedef logic [7:0] scan_code_t;

  // XT set-1 make code, bit 7 carries the break flag outside this type
  typedef logic [6:0] xt_code_t;

  // Frame bits received so far
  // Four bits hold up to 15, enough for an 11-bit frame
  typedef logic [3:0] bit_count_t;

endpackage

`default_nettype wire

//--- source/ps2_settings.svh
// Frame length, watchdog count and prefix value; watchdog assumes a 10 MHz wb_clk_i
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

// Start bit, eight data bits, parity bit and stop bit
`define PS2_FRAME_BITS 11

// Idle-high PS/2 clock time that discards a partial frame
// 600 cycles of a 10 MHz clock is 60 us
`define PS2_WATCHDOG_CYCLES 600

// Break prefix sent by the keyboard before a released key
`define PS2_RELEASE_CODE 8'hF0

`endif
